// ==== include/lms_cfg.svh ====
/*
 * LMS6002D front end configuration
 * Word widths, channel count and SPI device count
 */

`ifndef LMS_CFG_SVH
`define LMS_CFG_SVH

// Receive word as it comes off the transceiver ADC bus
`define LMS_ADC_W     12

// Receive sample after padding to the DSP width
`define LMS_SAMPLE_W  14

// Transmit word toward the transceiver DAC bus
`define LMS_DAC_W     12

// Two transceivers on the board
`define LMS_NUM_CH    2

// DAC, LMS 1 and LMS 2 on the shared SPI bus
`define LMS_SPI_DEVS  3

`endif

// ==== logic/lms_pkg.sv ====
/*
 * LMS front end types
 * Sample and DAC words, I/Q pairs, TX phase and SPI device index
 */

`include "lms_cfg.svh"

package lms_pkg;

   typedef logic [`LMS_SAMPLE_W-1:0] sample_t;   // Padded receive sample
   typedef logic [`LMS_DAC_W-1:0]    dac_word_t; // Transmit word

   // One receive I/Q pair, I in the upper half
   typedef struct packed {
      sample_t i;
      sample_t q;
   } rx_pair_t;

   typedef struct packed {
      dac_word_t i;
      dac_word_t q;
   } tx_pair_t;

   typedef enum logic {PH_I = 1'b0, PH_Q = 1'b1} iq_phase_e;

   // Bit position of each device in the enable vector
   typedef enum logic [1:0] {DEV_DAC = 2'd0, DEV_LMS1 = 2'd1, DEV_LMS2 = 2'd2} spi_dev_e;

endpackage

// ==== logic/lms_rx_capture.sv ====
/*
 * LMS receive capture
 * Splits one interleaved ADC port into an I/Q pair and strobes each full pair
 */

`timescale 1ns/1ps

`include "lms_cfg.svh"

module lms_rx_capture
(
   input  logic                   lms_clk,
   input  logic                   rst_n_i,
   input  logic [`LMS_ADC_W-1:0]  rx_d_i,
   input  logic                   rx_iqsel_i,
   output lms_pkg::rx_pair_t      pair_o,
   output logic                   pair_valid_o
);

   lms_pkg::sample_t i_q;       // Last I sample
   lms_pkg::sample_t q_q;       // Last Q sample
   lms_pkg::sample_t padded;
   logic             i_seen_q;  // I arrived since the last Q

   // ADC word goes to the top of the sample
   assign padded = {rx_d_i, {(`LMS_SAMPLE_W-`LMS_ADC_W){1'b0}}};

   always_ff @(posedge lms_clk)
   begin
      if (rx_iqsel_i)
         i_q <= padded;
      else
         q_q <= padded;
   end

   always_ff @(posedge lms_clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         i_seen_q     <= 1'b0;
         pair_valid_o <= 1'b0;
      end
      else if (rx_iqsel_i)
      begin
         i_seen_q     <= 1'b1;
         pair_valid_o <= 1'b0;
      end
      else
      begin
         // A lone Q word does not make a pair
         pair_valid_o <= i_seen_q;
         i_seen_q     <= 1'b0;
      end
   end

   assign pair_o.i = i_q;
   assign pair_o.q = q_q;

endmodule

// ==== logic/rx_channel_align.sv ====
/*
 * Receive channel alignment
 * Holds one pair per channel and releases both together once each has one,
 * with a sticky flag for a pair that got overwritten
 */

`timescale 1ns/1ps

module rx_channel_align
(
   input  logic              lms_clk,
   input  logic              rst_n_i,
   input  lms_pkg::rx_pair_t pair0_i,
   input  lms_pkg::rx_pair_t pair1_i,
   input  logic              pair0_valid_i,
   input  logic              pair1_valid_i,
   output lms_pkg::rx_pair_t aligned0_o,
   output lms_pkg::rx_pair_t aligned1_o,
   output logic              rx_valid_o,
   output logic              rx_overrun_o
);

   lms_pkg::rx_pair_t slot0_q, slot1_q;
   lms_pkg::rx_pair_t next0, next1;   // Newest pair per channel
   logic              full0_q, full1_q;
   logic              ready0, ready1;
   logic              release_w;

   // A strobe in this cycle counts as a full slot
   assign ready0    = full0_q | pair0_valid_i;
   assign ready1    = full1_q | pair1_valid_i;
   assign release_w = ready0 & ready1;

   assign next0 = pair0_valid_i ? pair0_i : slot0_q;
   assign next1 = pair1_valid_i ? pair1_i : slot1_q;

   always_ff @(posedge lms_clk)
   begin
      if (pair0_valid_i)
         slot0_q <= pair0_i;   // Newer pair always wins
      if (pair1_valid_i)
         slot1_q <= pair1_i;
   end

   always_ff @(posedge lms_clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         full0_q      <= 1'b0;
         full1_q      <= 1'b0;
         rx_valid_o   <= 1'b0;
         rx_overrun_o <= 1'b0;
         aligned0_o   <= '0;
         aligned1_o   <= '0;
      end
      else
      begin
         rx_valid_o <= release_w;
         if (release_w)
         begin
            aligned0_o <= next0;
            aligned1_o <= next1;
            full0_q    <= 1'b0;
            full1_q    <= 1'b0;
         end
         else
         begin
            if (pair0_valid_i)
               full0_q <= 1'b1;
            if (pair1_valid_i)
               full1_q <= 1'b1;
         end
         // Sticky until reset
         if ((pair0_valid_i && full0_q) || (pair1_valid_i && full1_q))
            rx_overrun_o <= 1'b1;
      end
   end

endmodule

// ==== logic/lms_tx_interleave.sv ====
/*
 * LMS transmit interleave
 * Takes both TX pairs on one edge and sends I then Q with the matching IQSEL
 */

`timescale 1ns/1ps

`include "lms_cfg.svh"

module lms_tx_interleave
(
   input  logic               lms_clk,
   input  logic               rst_n_i,
   input  lms_pkg::tx_pair_t  tx0_pair_i,
   input  lms_pkg::tx_pair_t  tx1_pair_i,
   output lms_pkg::dac_word_t tx0_d_o,
   output lms_pkg::dac_word_t tx1_d_o,
   output logic               tx0_iqsel_o,
   output logic               tx1_iqsel_o,
   output logic               tx_load_o
);

   lms_pkg::iq_phase_e phase_q;
   lms_pkg::tx_pair_t  pair_in [`LMS_NUM_CH];
   lms_pkg::dac_word_t q_hold  [`LMS_NUM_CH];  // Q half of the taken pair
   lms_pkg::dac_word_t d_q     [`LMS_NUM_CH];
   logic               iqsel_q;

   assign pair_in[0] = tx0_pair_i;
   assign pair_in[1] = tx1_pair_i;

   // I is sent straight away, only Q has to wait a cycle
   always_ff @(posedge lms_clk)
   begin
      if (phase_q == lms_pkg::PH_I)
      begin
         for (int ch = 0; ch < `LMS_NUM_CH; ch++)
            q_hold[ch] <= pair_in[ch].q;
      end
   end

   always_ff @(posedge lms_clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         phase_q   <= lms_pkg::PH_I;
         iqsel_q   <= 1'b0;
         tx_load_o <= 1'b0;
         for (int ch = 0; ch < `LMS_NUM_CH; ch++)
            d_q[ch] <= '0;
      end
      else if (phase_q == lms_pkg::PH_I)
      begin
         phase_q   <= lms_pkg::PH_Q;
         iqsel_q   <= 1'b0;           // IQSEL low marks I
         tx_load_o <= 1'b1;           // Source may move to its next pair
         for (int ch = 0; ch < `LMS_NUM_CH; ch++)
            d_q[ch] <= pair_in[ch].i;
      end
      else
      begin
         phase_q   <= lms_pkg::PH_I;
         iqsel_q   <= 1'b1;
         tx_load_o <= 1'b0;
         for (int ch = 0; ch < `LMS_NUM_CH; ch++)
            d_q[ch] <= q_hold[ch];
      end
   end

   assign tx0_d_o     = d_q[0];
   assign tx1_d_o     = d_q[1];
   assign tx0_iqsel_o = iqsel_q;   // Both DACs run in lock step
   assign tx1_iqsel_o = iqsel_q;

endmodule

// ==== logic/lms_spi_router.sv ====
/*
 * SPI router
 * Passes host clock and data only to the enabled device, merges LMS readback
 */

`timescale 1ns/1ps

`include "lms_cfg.svh"

module lms_spi_router
(
   input  logic                     sclk_i,
   input  logic                     mosi_i,
   input  logic [`LMS_SPI_DEVS-1:0] sen_n_i,      // Active low, one per device
   input  logic                     lms1_miso_i,
   input  logic                     lms2_miso_i,
   output logic [`LMS_SPI_DEVS-1:0] dev_sclk_o,
   output logic [`LMS_SPI_DEVS-1:0] dev_mosi_o,
   output logic                     miso_o
);

   logic lms1_sel, lms2_sel;

   // Idle devices see clock and data held low
   always_comb
   begin
      for (int dev = 0; dev < `LMS_SPI_DEVS; dev++)
      begin
         dev_sclk_o[dev] = sclk_i & ~sen_n_i[dev];
         dev_mosi_o[dev] = mosi_i & ~sen_n_i[dev];
      end
   end

   assign lms1_sel = ~sen_n_i[lms_pkg::DEV_LMS1];
   assign lms2_sel = ~sen_n_i[lms_pkg::DEV_LMS2];

   // DAC is write only
   assign miso_o = (lms1_sel & lms1_miso_i) | (lms2_sel & lms2_miso_i);

endmodule

// ==== logic/lms_frontend.sv ====
/*
 * LMS6002D front end top level
 * Receive capture and alignment for two transceivers, TX interleave, SPI routing
 */

`timescale 1ns/1ps

`include "lms_cfg.svh"

module lms_frontend
(
   input  logic                     lms_clk,
   input  logic                     rst_n_i,
   // Receive ports
   input  logic [`LMS_ADC_W-1:0]    lms0_rx_d_i,
   input  logic                     lms0_rx_iqsel_i,
   input  logic [`LMS_ADC_W-1:0]    lms1_rx_d_i,
   input  logic                     lms1_rx_iqsel_i,
   // Transmit pairs from the DSP side
   input  logic [`LMS_DAC_W-1:0]    tx0_i_i,
   input  logic [`LMS_DAC_W-1:0]    tx0_q_i,
   input  logic [`LMS_DAC_W-1:0]    tx1_i_i,
   input  logic [`LMS_DAC_W-1:0]    tx1_q_i,
   // Host SPI
   input  logic                     spi_sclk_i,
   input  logic                     spi_mosi_i,
   input  logic [`LMS_SPI_DEVS-1:0] spi_sen_n_i,
   input  logic                     lms1_miso_i,
   input  logic                     lms2_miso_i,
   // Aligned receive samples
   output logic [`LMS_SAMPLE_W-1:0] rx0_i_o,
   output logic [`LMS_SAMPLE_W-1:0] rx0_q_o,
   output logic [`LMS_SAMPLE_W-1:0] rx1_i_o,
   output logic [`LMS_SAMPLE_W-1:0] rx1_q_o,
   output logic                     rx_valid_o,
   output logic                     rx_overrun_o,
   // Transceiver DAC buses
   output logic [`LMS_DAC_W-1:0]    lms0_tx_d_o,
   output logic                     lms0_tx_iqsel_o,
   output logic [`LMS_DAC_W-1:0]    lms1_tx_d_o,
   output logic                     lms1_tx_iqsel_o,
   output logic                     tx_load_o,
   // Device SPI pins
   output logic [`LMS_SPI_DEVS-1:0] spi_sclk_o,
   output logic [`LMS_SPI_DEVS-1:0] spi_mosi_o,
   output logic [`LMS_SPI_DEVS-1:0] spi_sen_n_o,
   output logic                     spi_miso_o
);

   lms_pkg::rx_pair_t cap0_pair, cap1_pair;
   logic              cap0_valid, cap1_valid;
   lms_pkg::rx_pair_t aligned0, aligned1;
   lms_pkg::tx_pair_t tx0_pair, tx1_pair;

   lms_rx_capture u_rx_cap0 (
      .lms_clk      (lms_clk),
      .rst_n_i      (rst_n_i),
      .rx_d_i       (lms0_rx_d_i),
      .rx_iqsel_i   (lms0_rx_iqsel_i),
      .pair_o       (cap0_pair),
      .pair_valid_o (cap0_valid)
   );

   lms_rx_capture u_rx_cap1 (
      .lms_clk      (lms_clk),
      .rst_n_i      (rst_n_i),
      .rx_d_i       (lms1_rx_d_i),
      .rx_iqsel_i   (lms1_rx_iqsel_i),
      .pair_o       (cap1_pair),
      .pair_valid_o (cap1_valid)
   );

   rx_channel_align u_rx_align (
      .lms_clk       (lms_clk),
      .rst_n_i       (rst_n_i),
      .pair0_i       (cap0_pair),
      .pair1_i       (cap1_pair),
      .pair0_valid_i (cap0_valid),
      .pair1_valid_i (cap1_valid),
      .aligned0_o    (aligned0),
      .aligned1_o    (aligned1),
      .rx_valid_o    (rx_valid_o),
      .rx_overrun_o  (rx_overrun_o)
   );

   assign rx0_i_o = aligned0.i;
   assign rx0_q_o = aligned0.q;
   assign rx1_i_o = aligned1.i;
   assign rx1_q_o = aligned1.q;

   assign tx0_pair = {tx0_i_i, tx0_q_i};   // I in the upper half
   assign tx1_pair = {tx1_i_i, tx1_q_i};

   lms_tx_interleave u_tx (
      .lms_clk     (lms_clk),
      .rst_n_i     (rst_n_i),
      .tx0_pair_i  (tx0_pair),
      .tx1_pair_i  (tx1_pair),
      .tx0_d_o     (lms0_tx_d_o),
      .tx1_d_o     (lms1_tx_d_o),
      .tx0_iqsel_o (lms0_tx_iqsel_o),
      .tx1_iqsel_o (lms1_tx_iqsel_o),
      .tx_load_o   (tx_load_o)
   );

   lms_spi_router u_spi (
      .sclk_i      (spi_sclk_i),
      .mosi_i      (spi_mosi_i),
      .sen_n_i     (spi_sen_n_i),
      .lms1_miso_i (lms1_miso_i),
      .lms2_miso_i (lms2_miso_i),
      .dev_sclk_o  (spi_sclk_o),
      .dev_mosi_o  (spi_mosi_o),
      .miso_o      (spi_miso_o)
   );

   assign spi_sen_n_o = spi_sen_n_i;   // Enables go to the pins untouched

endmodule

// ==== bench/tb_lms_frontend.sv ====
/*
 * Testbench for the LMS6002D front end
 * Drives receive words, transmit pairs and SPI traffic, checks against reference models
 */

`timescale 1ns/1ps

`include "lms_cfg.svh"

module tb_lms_frontend;

   localparam int N_PAIRS     = 8;
   localparam int SKEW        = 5;    // Cycles between the two Q edges
   localparam int TX_CYCLES   = 40;
   localparam int SPI_CYCLES  = 40;
   localparam int TEST_CYCLES = 3 + 4 * N_PAIRS + (SKEW + 6) + 9 + TX_CYCLES + SPI_CYCLES + 4;
   localparam int TIMEOUT_CYC = 2 * TEST_CYCLES;

   logic                     lms_clk;
   logic                     rst_n_i;
   logic [`LMS_ADC_W-1:0]    lms0_rx_d_i, lms1_rx_d_i;
   logic                     lms0_rx_iqsel_i, lms1_rx_iqsel_i;
   logic [`LMS_DAC_W-1:0]    tx0_i_i, tx0_q_i, tx1_i_i, tx1_q_i;
   logic                     spi_sclk_i, spi_mosi_i, lms1_miso_i, lms2_miso_i;
   logic [`LMS_SPI_DEVS-1:0] spi_sen_n_i;
   logic [`LMS_SAMPLE_W-1:0] rx0_i_o, rx0_q_o, rx1_i_o, rx1_q_o;
   logic                     rx_valid_o, rx_overrun_o;
   logic [`LMS_DAC_W-1:0]    lms0_tx_d_o, lms1_tx_d_o;
   logic                     lms0_tx_iqsel_o, lms1_tx_iqsel_o, tx_load_o;
   logic [`LMS_SPI_DEVS-1:0] spi_sclk_o, spi_mosi_o, spi_sen_n_o;
   logic                     spi_miso_o;

   integer seed;
   int     cyc = 0;
   int     errors = 0;
   int     checks = 0;
   string  test_name;
   int     ovr_cyc;     // First cycle the overrun flag must show
   int     last_load;   // Cycle of the last load pulse or -1
   int     rx_exp_cyc_q[$];
   logic [3:0][`LMS_SAMPLE_W-1:0] rx_exp_q[$];   // i0, q0, i1, q1
   logic [3:0][`LMS_SAMPLE_W-1:0] rx_exp;
   logic [2*`LMS_DAC_W-1:0]       tx_hold0, tx_hold1;
   logic [2*`LMS_SPI_DEVS:0]      spi_exp;
   logic [`LMS_ADC_W-1:0]         ai, aq, bi, bq, ci, cq, rnd;

   lms_frontend UUT (.*);

   always #20 lms_clk = ~lms_clk;

   function automatic logic [`LMS_ADC_W-1:0] rand_word();
      int r;
      r = $random(seed);
      return r[`LMS_ADC_W-1:0];
   endfunction

   // ADC word with two zero bits below it
   function automatic logic [`LMS_SAMPLE_W-1:0] pad_word(input logic [`LMS_ADC_W-1:0] w);
      return {w, 2'b00};
   endfunction

   function automatic logic [`LMS_DAC_W-1:0] tx_expect(input logic [2*`LMS_DAC_W-1:0] pair,
                                                        input lms_pkg::iq_phase_e ph);
      if (ph == lms_pkg::PH_Q)
         return pair[`LMS_DAC_W-1:0];
      return pair[2*`LMS_DAC_W-1:`LMS_DAC_W];
   endfunction

   // Packed as sclk, mosi, miso
   function automatic logic [2*`LMS_SPI_DEVS:0] spi_expect(input logic [`LMS_SPI_DEVS-1:0] sen_n,
                                                          input logic sclk, input logic mosi,
                                                          input logic m1, input logic m2);
      logic [`LMS_SPI_DEVS-1:0] sclk_e, mosi_e;
      logic                     miso_e;
      for (int d = 0; d < `LMS_SPI_DEVS; d++)
      begin
         sclk_e[d] = sen_n[d] ? 1'b0 : sclk;
         mosi_e[d] = sen_n[d] ? 1'b0 : mosi;
      end
      miso_e = (!sen_n[1] && m1) || (!sen_n[2] && m2);   // DAC never answers
      return {sclk_e, mosi_e, miso_e};
   endfunction

   task automatic check_val(input string sig, input logic [31:0] exp, input logic [31:0] act);
      checks++;
      assert (exp === act)
      else
      begin
         errors++;
         $display("ERR %s %s: expected %h, actual %h", test_name, sig, exp, act);
      end
   endtask

   task automatic rx_step(input logic sel0, input logic [`LMS_ADC_W-1:0] d0,
                          input logic sel1, input logic [`LMS_ADC_W-1:0] d1);
      @(posedge lms_clk);
      lms0_rx_iqsel_i <= sel0;
      lms0_rx_d_i     <= d0;
      lms1_rx_iqsel_i <= sel1;
      lms1_rx_d_i     <= d1;
   endtask

   // Runs right after the later Q edge while cyc still holds the count before it
   task automatic expect_rx(input logic [`LMS_ADC_W-1:0] i0, q0, i1, q1);
      rx_exp_cyc_q.push_back(cyc + 3);
      rx_exp_q.push_back({pad_word(i0), pad_word(q0), pad_word(i1), pad_word(q1)});
   endtask

   always @(posedge lms_clk)
   begin
      cyc <= cyc + 1;
      if (cyc >= TIMEOUT_CYC)
      begin
         $display("Timeout: run passed %0d cycles with %0d errors", TIMEOUT_CYC, errors);
         $display("Simulation FAILED");
         $finish;
      end
   end

   // Outputs settle well before the falling edge
   always @(negedge lms_clk)
   begin
      if (!rst_n_i)
      begin
         check_val("rx_valid_o", 32'd0, 32'(rx_valid_o));
         check_val("rx_overrun_o", 32'd0, 32'(rx_overrun_o));
         check_val("tx_load_o", 32'd0, 32'(tx_load_o));
         check_val("lms0_tx_iqsel_o", 32'd0, 32'(lms0_tx_iqsel_o));
         check_val("lms1_tx_iqsel_o", 32'd0, 32'(lms1_tx_iqsel_o));
      end
      else
      begin
         if (rx_exp_cyc_q.size() > 0 && rx_exp_cyc_q[0] == cyc)
         begin
            assert (rx_valid_o)
            else
            begin
               errors++;
               $display("%s: rx_valid_o pulse missing at cycle %0d", test_name, cyc);
            end
            rx_exp = rx_exp_q.pop_front();
            void'(rx_exp_cyc_q.pop_front());
            check_val("rx0_i_o", 32'(rx_exp[3]), 32'(rx0_i_o));
            check_val("rx0_q_o", 32'(rx_exp[2]), 32'(rx0_q_o));
            check_val("rx1_i_o", 32'(rx_exp[1]), 32'(rx1_i_o));
            check_val("rx1_q_o", 32'(rx_exp[0]), 32'(rx1_q_o));
         end
         else
         begin
            assert (!rx_valid_o)
            else
            begin
               errors++;
               $display("%s: rx_valid_o pulsed with no pair due at cycle %0d", test_name, cyc);
            end
         end
         check_val("rx_overrun_o", 32'(cyc >= ovr_cyc), 32'(rx_overrun_o));

         if (tx_load_o)
         begin
            if (last_load >= 0)
            begin
               assert (cyc - last_load == 2)
               else
               begin
                  errors++;
                  $display("%s: tx_load_o pulses %0d cycles apart", test_name, cyc - last_load);
               end
            end
            tx_hold0 = {tx0_i_i, tx0_q_i};   // Inputs still hold the pair just taken
            tx_hold1 = {tx1_i_i, tx1_q_i};
            check_val("lms0_tx_d_o I", 32'(tx_expect(tx_hold0, lms_pkg::PH_I)), 32'(lms0_tx_d_o));
            check_val("lms1_tx_d_o I", 32'(tx_expect(tx_hold1, lms_pkg::PH_I)), 32'(lms1_tx_d_o));
            check_val("lms0_tx_iqsel_o", 32'd0, 32'(lms0_tx_iqsel_o));
            check_val("lms1_tx_iqsel_o", 32'd0, 32'(lms1_tx_iqsel_o));
            last_load = cyc;
         end
         else if (last_load >= 0)
         begin
            assert (cyc - last_load == 1)
            else
            begin
               errors++;
               $display("%s: tx_load_o pulse missing at cycle %0d", test_name, cyc);
            end
            check_val("lms0_tx_d_o Q", 32'(tx_expect(tx_hold0, lms_pkg::PH_Q)), 32'(lms0_tx_d_o));
            check_val("lms1_tx_d_o Q", 32'(tx_expect(tx_hold1, lms_pkg::PH_Q)), 32'(lms1_tx_d_o));
            check_val("lms0_tx_iqsel_o", 32'd1, 32'(lms0_tx_iqsel_o));
            check_val("lms1_tx_iqsel_o", 32'd1, 32'(lms1_tx_iqsel_o));
         end

         spi_exp = spi_expect(spi_sen_n_i, spi_sclk_i, spi_mosi_i, lms1_miso_i, lms2_miso_i);
         check_val("spi_sclk_o", 32'(spi_exp[2*`LMS_SPI_DEVS:`LMS_SPI_DEVS+1]), 32'(spi_sclk_o));
         check_val("spi_mosi_o", 32'(spi_exp[`LMS_SPI_DEVS:1]), 32'(spi_mosi_o));
         check_val("spi_miso_o", 32'(spi_exp[0]), 32'(spi_miso_o));
         check_val("spi_sen_n_o", 32'(spi_sen_n_i), 32'(spi_sen_n_o));
      end
   end

   initial
   begin
      seed            = 32'hb5f6;
      lms_clk         = 1'b0;
      rst_n_i         = 1'b0;
      lms0_rx_d_i     = '0;
      lms1_rx_d_i     = '0;
      lms0_rx_iqsel_i = 1'b0;
      lms1_rx_iqsel_i = 1'b0;
      tx0_i_i         = '0;
      tx0_q_i         = '0;
      tx1_i_i         = '0;
      tx1_q_i         = '0;
      spi_sclk_i      = 1'b0;
      spi_mosi_i      = 1'b0;
      spi_sen_n_i     = '1;
      lms1_miso_i     = 1'b0;
      lms2_miso_i     = 1'b0;
      ovr_cyc         = 32'h7fff_ffff;
      last_load       = -1;
      test_name       = "reset";
      repeat (3) @(posedge lms_clk);
      rst_n_i <= 1'b1;

      test_name = "rx_pairs";
      for (int k = 0; k < N_PAIRS; k++)
      begin
         ai = rand_word();
         aq = rand_word();
         ci = rand_word();
         cq = rand_word();
         rx_step(1'b1, ai, 1'b1, ci);
         rx_step(1'b0, aq, 1'b0, cq);
         expect_rx(ai, aq, ci, cq);
         bi = rand_word();
         bq = rand_word();
         rx_step(1'b0, bi, 1'b0, bq);   // Lone Q words make no pair
         rx_step(1'b0, '0, 1'b0, '0);
      end

      test_name = "rx_skew";
      ai = rand_word();
      aq = rand_word();
      ci = rand_word();
      cq = rand_word();
      rx_step(1'b1, ai, 1'b1, ci);
      rx_step(1'b0, aq, 1'b1, ci);
      repeat (SKEW)
      begin
         rnd = rand_word();
         rx_step(1'b0, rnd, 1'b1, ci);   // Channel 1 keeps sending I
      end
      rx_step(1'b0, '0, 1'b0, cq);
      expect_rx(ai, aq, ci, cq);
      repeat (3) rx_step(1'b0, '0, 1'b0, '0);

      test_name = "rx_overrun";
      ai = rand_word();
      aq = rand_word();
      bi = rand_word();
      bq = rand_word();
      ci = rand_word();
      cq = rand_word();
      rx_step(1'b1, ai, 1'b1, ci);
      rx_step(1'b0, aq, 1'b1, ci);
      rx_step(1'b1, bi, 1'b1, ci);
      rx_step(1'b0, bq, 1'b1, ci);
      ovr_cyc = cyc + 3;   // Second strobe hits a full slot
      rnd = rand_word();
      rx_step(1'b0, rnd, 1'b1, ci);
      rx_step(1'b0, '0, 1'b0, cq);
      expect_rx(bi, bq, ci, cq);
      repeat (3) rx_step(1'b0, '0, 1'b0, '0);

      test_name = "tx_interleave";
      repeat (TX_CYCLES)
      begin
         @(posedge lms_clk);
         if (tx_load_o)   // Pair was taken so move on to the next one
         begin
            tx0_i_i <= rand_word();
            tx0_q_i <= rand_word();
            tx1_i_i <= rand_word();
            tx1_q_i <= rand_word();
         end
      end

      test_name = "spi_route";
      repeat (SPI_CYCLES)
      begin
         @(posedge lms_clk);
         rnd = rand_word();
         spi_sclk_i  <= rnd[0];
         spi_mosi_i  <= rnd[1];
         lms1_miso_i <= rnd[2];
         lms2_miso_i <= rnd[3];
         spi_sen_n_i <= rnd[4 +: `LMS_SPI_DEVS];
      end

      repeat (4) @(posedge lms_clk);
      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("Simulation PASSED");
      else
         $display("Simulation FAILED");
      $finish;
   end

endmodule

// ==== files.f ====
+incdir+include
logic/lms_pkg.sv
logic/lms_rx_capture.sv
logic/rx_channel_align.sv
logic/lms_tx_interleave.sv
logic/lms_spi_router.sv
logic/lms_frontend.sv
bench/tb_lms_frontend.sv

// ==== Makefile ====
# Verilator flow for the LMS front end

VERILATOR ?= verilator
FILELIST  ?= files.f
TOP       ?= tb_lms_frontend
RTL_TOP   ?= lms_frontend
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# Pass only when the testbench prints its pass line
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR)
